// ==== flist.f ====
src/exec_pkg.sv
src/shift_unit.sv
src/alu.sv
src/instr_decoder.sv
src/reg_file.sv
src/exec_unit.sv
verif/exec_unit_assertions.sv
verif/exec_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module exec_unit_tb -f flist.f -o exec_unit_sim

status=0
output=$(./obj_dir/exec_unit_sim 2>&1) || status=$?
echo "$output"

if echo "$output" | grep -qxF "PASS: all tests"; then
    exit 0
fi
exit 1

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    input  exec_pkg::word_t   imm_ext,
    input  exec_pkg::shamt_t  shamt,
    input  logic              use_imm,
    input  logic              var_shift,
    input  exec_pkg::alu_op_t alu_op,
    output exec_pkg::word_t   result,
    output logic              zero,
    output logic              positive,
    output logic              negative
);
    import exec_pkg::*;

    word_t       operand_b;     // rt or immediate.
    word_t       shift_result;
    shamt_t      shift_amount;
    shift_kind_t shift_kind;

    assign operand_b = use_imm ? imm_ext : b;

    // ==================================================
    // Shifter
    // ==================================================
    assign shift_amount = var_shift ? a[4:0] : shamt;  // Only rs[4:0] counts.

    always_comb begin
        case (alu_op)
            ALU_SLL: shift_kind = SHIFT_LL;
            ALU_SRA: shift_kind = SHIFT_RA;
            default: shift_kind = SHIFT_RL;
        endcase
    end

    shift_unit shift_unit_i (
        .shift_value  (b),        // Shifts always act on rt.
        .shift_amount (shift_amount),
        .shift_kind   (shift_kind),
        .shift_result (shift_result)
    );

    // ==================================================
    // Result select
    // ==================================================
    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + operand_b;  // Wraps, no trap.
            ALU_SUB:  result = a - operand_b;
            ALU_AND:  result = a & operand_b;
            ALU_OR:   result = a | operand_b;
            ALU_XOR:  result = a ^ operand_b;
            ALU_SLTU: result = {31'b0, (a < operand_b)};  // Unsigned compare.
            ALU_SLL,
            ALU_SRL,
            ALU_SRA:  result = shift_result;
            default:  result = '0;
        endcase
    end

    // ==================================================
    // Flags
    // ==================================================
    assign negative = result[31];              // Sign bit.
    assign zero     = (result == '0);
    assign positive = !zero && !negative;      // Nonzero with bit 31 clear.

endmodule

// ==== src/exec_pkg.sv ====
package exec_pkg;

    // ==================================================
    // Field and word types
    // ==================================================
    typedef logic [31:0] word_t;      // Data or instruction word.
    typedef logic [4:0]  reg_addr_t;  // Register number.
    typedef logic [4:0]  shamt_t;     // Shift amount.
    typedef logic [5:0]  opcode_t;    // Major opcode, bits 31:26.
    typedef logic [5:0]  funct_t;     // Function field of opcode 0, bits 5:0.

    localparam int NUM_REGS = 32;     // Register file depth.

    // ==================================================
    // Opcodes and function codes
    // ==================================================
    localparam opcode_t OPCODE_SPECIAL = 6'd0;  // Register-register group.
    localparam opcode_t OPCODE_ADDIU   = 6'd9;  // Add immediate unsigned.

    localparam funct_t FUNCT_SLL  = 6'h00;  // Shift left by shamt.
    localparam funct_t FUNCT_SRL  = 6'h02;  // Shift right logical by shamt.
    localparam funct_t FUNCT_SRA  = 6'h03;  // Shift right arithmetic by shamt.
    localparam funct_t FUNCT_SLLV = 6'h04;  // Shift left by rs.
    localparam funct_t FUNCT_SRLV = 6'h06;  // Shift right logical by rs.
    localparam funct_t FUNCT_SRAV = 6'h07;  // Shift right arithmetic by rs.
    localparam funct_t FUNCT_ADDU = 6'h21;  // Add, no trap.
    localparam funct_t FUNCT_SUBU = 6'h23;  // Subtract, no trap.
    localparam funct_t FUNCT_AND  = 6'h24;
    localparam funct_t FUNCT_OR   = 6'h25;
    localparam funct_t FUNCT_XOR  = 6'h26;
    localparam funct_t FUNCT_SLTU = 6'h2b;  // Unsigned set-less-than.

    // ==================================================
    // Datapath controls
    // ==================================================
    typedef enum logic [3:0] {
        ALU_ADD,   // a + b.
        ALU_SUB,   // a - b.
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLTU,  // 1 when a < b unsigned.
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    typedef enum logic [1:0] {
        SHIFT_LL,  // Logical left.
        SHIFT_RL,  // Logical right, zero fill.
        SHIFT_RA   // Arithmetic right, sign fill.
    } shift_kind_t;

endpackage

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  exec_pkg::word_t instr,
    output logic            result_valid,
    output exec_pkg::word_t result,
    output logic            zero,
    output logic            positive,
    output logic            negative,
    output logic            illegal
);
    import exec_pkg::*;

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t wb_addr;
    shamt_t    shamt;
    word_t     imm_ext;
    logic      use_imm;
    logic      var_shift;
    logic      wb_en;
    logic      dec_illegal;
    alu_op_t   alu_op;
    word_t     rs_data;
    word_t     rt_data;
    word_t     alu_result;
    logic      alu_zero;
    logic      alu_positive;
    logic      alu_negative;

    instr_decoder instr_decoder_i (
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .wb_addr     (wb_addr),
        .shamt       (shamt),
        .imm_ext     (imm_ext),
        .use_imm     (use_imm),
        .var_shift   (var_shift),
        .wb_en       (wb_en),
        .illegal     (dec_illegal),
        .alu_op      (alu_op)
    );

    reg_file reg_file_i (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wb_addr (wb_addr),
        .wb_en   (wb_en),
        .wb_data (alu_result),  // Write-back at the same edge as the output.
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu alu_i (
        .a         (rs_data),
        .b         (rt_data),
        .imm_ext   (imm_ext),
        .shamt     (shamt),
        .use_imm   (use_imm),
        .var_shift (var_shift),
        .alu_op    (alu_op),
        .result    (alu_result),
        .zero      (alu_zero),
        .positive  (alu_positive),
        .negative  (alu_negative)
    );

    // ==================================================
    // Output registers, one cycle latency
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            result       <= '0;
            zero         <= 1'b1;  // Matches a zero result.
            positive     <= 1'b0;
            negative     <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            result_valid <= instr_valid;  // One-cycle echo of the strobe.
            if (instr_valid) begin
                illegal <= dec_illegal;
                if (dec_illegal) begin
                    result   <= '0;    // Illegal words report zero.
                    zero     <= 1'b1;
                    positive <= 1'b0;
                    negative <= 1'b0;
                end else begin
                    result   <= alu_result;
                    zero     <= alu_zero;
                    positive <= alu_positive;
                    negative <= alu_negative;
                end
            end
        end
    end

endmodule

// ==== src/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  logic               instr_valid,
    input  exec_pkg::word_t    instr,
    output exec_pkg::reg_addr_t rs_addr,
    output exec_pkg::reg_addr_t rt_addr,
    output exec_pkg::reg_addr_t wb_addr,
    output exec_pkg::shamt_t   shamt,
    output exec_pkg::word_t    imm_ext,
    output logic               use_imm,
    output logic               var_shift,
    output logic               wb_en,
    output logic               illegal,
    output exec_pkg::alu_op_t  alu_op
);
    import exec_pkg::*;

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rd_addr;

    // ==================================================
    // Field split
    // ==================================================
    assign opcode  = instr[31:26];
    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign rd_addr = instr[15:11];
    assign shamt   = instr[10:6];
    assign funct   = instr[5:0];
    assign imm_ext = {{16{instr[15]}}, instr[15:0]};  // Sign-extended immediate.

    // ==================================================
    // Operation select
    // ==================================================
    always_comb begin
        alu_op    = ALU_ADD;   // Harmless default for illegal words.
        use_imm   = 1'b0;
        var_shift = 1'b0;
        illegal   = 1'b0;
        wb_addr   = rd_addr;   // R-type writes rd.
        case (opcode)
            OPCODE_SPECIAL: begin
                case (funct)
                    FUNCT_ADDU: alu_op = ALU_ADD;
                    FUNCT_SUBU: alu_op = ALU_SUB;
                    FUNCT_AND:  alu_op = ALU_AND;
                    FUNCT_OR:   alu_op = ALU_OR;
                    FUNCT_XOR:  alu_op = ALU_XOR;
                    FUNCT_SLTU: alu_op = ALU_SLTU;
                    FUNCT_SLL:  alu_op = ALU_SLL;
                    FUNCT_SRL:  alu_op = ALU_SRL;
                    FUNCT_SRA:  alu_op = ALU_SRA;
                    FUNCT_SLLV: begin
                        alu_op    = ALU_SLL;
                        var_shift = 1'b1;  // Amount from rs[4:0].
                    end
                    FUNCT_SRLV: begin
                        alu_op    = ALU_SRL;
                        var_shift = 1'b1;
                    end
                    FUNCT_SRAV: begin
                        alu_op    = ALU_SRA;
                        var_shift = 1'b1;
                    end
                    default: illegal = 1'b1;  // Unused funct.
                endcase
            end
            OPCODE_ADDIU: begin
                alu_op  = ALU_ADD;
                use_imm = 1'b1;
                wb_addr = rt_addr;  // I-type writes rt.
            end
            default: illegal = 1'b1;  // Unused opcode.
        endcase
    end

    // No write for idle cycles, illegal words or register 0.
    assign wb_en = instr_valid && !illegal && (wb_addr != '0);

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  exec_pkg::reg_addr_t rs_addr,
    input  exec_pkg::reg_addr_t rt_addr,
    input  exec_pkg::reg_addr_t wb_addr,
    input  logic                wb_en,
    input  exec_pkg::word_t     wb_data,
    output exec_pkg::word_t     rs_data,
    output exec_pkg::word_t     rt_data
);
    import exec_pkg::*;

    word_t regs [NUM_REGS];  // Storage, entry 0 unused.

    // ==================================================
    // Write port
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;  // Architectural state starts at zero.
            end
        end else if (wb_en && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;  // Register 0 never written.
        end
    end

    // ==================================================
    // Read ports
    // ==================================================
    // Zero latency, so a write is seen by the next cycle's read.
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// ==== src/shift_unit.sv ====
`timescale 1ns/1ps

module shift_unit (
    input  exec_pkg::word_t       shift_value,
    input  exec_pkg::shamt_t      shift_amount,
    input  exec_pkg::shift_kind_t shift_kind,
    output exec_pkg::word_t       shift_result
);
    import exec_pkg::*;

    word_t stage [6];   // Stage 0 is the input, stage 5 the result.
    logic  shift_left;  // Direction select.
    logic  fill;        // Bit shifted in on right shifts.

    assign shift_left = (shift_kind == SHIFT_LL);
    assign fill       = (shift_kind == SHIFT_RA) && shift_value[31];  // Sign fill.
    assign stage[0]   = shift_value;

    // ==================================================
    // Logarithmic stages, distances 1, 2, 4, 8, 16
    // ==================================================
    for (genvar s = 0; s < 5; s++) begin : g_stage
        always_comb begin
            if (!shift_amount[s]) begin
                stage[s+1] = stage[s];  // Bit clear, pass through.
            end else if (shift_left) begin
                stage[s+1] = {stage[s][31-(1<<s):0], {(1<<s){1'b0}}};
            end else begin
                stage[s+1] = {{(1<<s){fill}}, stage[s][31:(1<<s)]};
            end
        end
    end

    assign shift_result = stage[5];

endmodule

// ==== verif/exec_unit_assertions.sv ====
`timescale 1ns/1ps

module exec_unit_assertions (
    input logic            clk,
    input logic            rst,
    input logic            instr_valid,
    input logic            result_valid,
    input exec_pkg::word_t result,
    input logic            illegal
);

    // ==================================================
    // Output strobe
    // ==================================================
    // Result strobe is the strobe of the cycle before.
    valid_echo: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (result_valid == $past(instr_valid)))
        else $error("result_valid does not echo the previous instr_valid");

    // Nothing reported in the first cycle out of reset.
    reset_idle: assert property (@(posedge clk)
        $past(rst) |-> !result_valid)
        else $error("result_valid high right after reset");

    // ==================================================
    // Illegal words
    // ==================================================
    illegal_zero: assert property (@(posedge clk) disable iff (rst)
        illegal |-> (result == '0))
        else $error("illegal flag set with a nonzero result");

endmodule

bind exec_unit exec_unit_assertions exec_unit_assertions_i (.*);

// ==== verif/exec_unit_tb.sv ====
`timescale 1ns/1ps

module exec_unit_tb;
    import exec_pkg::*;

    // Instructions issued by all tests together, three cycles allowed per instruction.
    localparam int ISSUED      = 54;
    localparam int CYCLE_LIMIT = 16 + 3 * ISSUED + 100;

    logic  clk;
    logic  rst;
    logic  instr_valid;
    word_t instr;
    logic  result_valid;
    word_t result;
    logic  zero;
    logic  positive;
    logic  negative;
    logic  illegal;

    word_t shadow [NUM_REGS];           // Model of the register file.
    word_t lfsr_state = 32'h761f_222d;
    word_t chain_q [$];                 // Words issued back to back.
    int    check_count = 0;
    int    error_count = 0;
    int    cycle_count = 0;

    exec_unit exec_unit_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;         // 40 ns period.
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    // ==================================================
    // Stimulus helpers and reference model
    // ==================================================
    function automatic word_t lfsr_take(input int nbits);
        word_t bits;
        logic  fb;
        bits = '0;
        for (int k = 0; k < nbits; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};  // One step per bit taken.
        end
        return bits;
    endfunction

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input shamt_t sh, input funct_t fn);
        return {OPCODE_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_type(input opcode_t op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Expected result of one word, then write-back into the shadow registers.
    function automatic void model_step(input word_t w, output word_t res, output logic ill);
        word_t     a;
        word_t     b;
        reg_addr_t dest;
        a    = shadow[w[25:21]];
        b    = shadow[w[20:16]];
        dest = w[15:11];
        res  = '0;
        ill  = 1'b0;
        if (w[31:26] == OPCODE_ADDIU) begin
            res  = a + {{16{w[15]}}, w[15:0]};
            dest = w[20:16];
        end else if (w[31:26] != OPCODE_SPECIAL) begin
            ill = 1'b1;
        end else begin
            case (w[5:0])
                FUNCT_ADDU: res = a + b;
                FUNCT_SUBU: res = a - b;
                FUNCT_AND:  res = a & b;
                FUNCT_OR:   res = a | b;
                FUNCT_XOR:  res = a ^ b;
                FUNCT_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                FUNCT_SLL:  res = b << w[10:6];
                FUNCT_SRL:  res = b >> w[10:6];
                FUNCT_SRA:  res = $signed(b) >>> w[10:6];
                FUNCT_SLLV: res = b << a[4:0];
                FUNCT_SRLV: res = b >> a[4:0];
                FUNCT_SRAV: res = $signed(b) >>> a[4:0];
                default:    ill = 1'b1;
            endcase
        end
        if (!ill && dest != 5'd0) begin
            shadow[dest] = res;
        end
    endfunction

    // ==================================================
    // Checks
    // ==================================================
    task automatic compare_word(input string name, input word_t got, input word_t exp);
        check_count++;
        assert (got === exp) else begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_count++;
        assert (got === exp) else begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_outputs(input word_t exp_res, input logic exp_ill);
        compare_bit("result_valid", result_valid, 1'b1);
        compare_bit("illegal", illegal, exp_ill);
        compare_word("result", result, exp_res);
        compare_bit("zero", zero, exp_res == '0);
        compare_bit("negative", negative, exp_res[31]);
        compare_bit("positive", positive, (exp_res != '0) && !exp_res[31]);
    endtask

    task automatic wait_result();
        while (result_valid !== 1'b1) begin
            @(negedge clk);             // Bounded by the cycle watchdog.
        end
    endtask

    task automatic run_instr(input word_t w);
        word_t exp_res;
        logic  exp_ill;
        model_step(w, exp_res, exp_ill);
        @(negedge clk);
        instr       = w;
        instr_valid = 1'b1;
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = '0;
        wait_result();
        check_outputs(exp_res, exp_ill);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_reset();
        compare_bit("result_valid", result_valid, 1'b0);
        compare_bit("illegal", illegal, 1'b0);
        compare_word("result", result, '0);
        compare_bit("zero", zero, 1'b1);
        compare_bit("positive", positive, 1'b0);
        compare_bit("negative", negative, 1'b0);
        run_instr(r_type(5'd0, 5'd0, 5'd3, 5'd0, FUNCT_ADDU));
        run_instr(r_type(5'd7, 5'd8, 5'd4, 5'd0, FUNCT_OR));  // Cleared registers.
    endtask

    task automatic test_immediate();
        word_t       pick;
        logic [15:0] imm;
        reg_addr_t   src;
        for (int r = 1; r <= 8; r++) begin
            pick = lfsr_take(16);
            imm  = pick[15:0];
            if (r <= 4) begin
                imm[15] = (r % 2 == 1);  // Odd registers negative, even positive.
            end
            src = (r <= 4) ? 5'd0 : reg_addr_t'(r - 4);
            run_instr(i_type(OPCODE_ADDIU, src, reg_addr_t'(r), imm));
        end
        run_instr(i_type(OPCODE_ADDIU, 5'd1, 5'd0, 16'h8001));   // Reported, not kept.
        run_instr(r_type(5'd0, 5'd0, 5'd9, 5'd0, FUNCT_OR));
        run_instr(i_type(OPCODE_ADDIU, 5'd0, 5'd10, 16'h0000));  // Zero result.
    endtask

    task automatic test_alu_logic();
        funct_t    ops [6];
        word_t     pick;
        reg_addr_t rs;
        reg_addr_t rt;
        ops = '{FUNCT_ADDU, FUNCT_SUBU, FUNCT_AND, FUNCT_OR, FUNCT_XOR, FUNCT_SLTU};
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 2; j++) begin
                pick = lfsr_take(6);
                rs   = {2'b00, pick[2:0]} + 5'd1;  // Registers 1 to 8.
                rt   = {2'b00, pick[5:3]} + 5'd1;
                run_instr(r_type(rs, rt, reg_addr_t'(11 + 2 * i + j), 5'd0, ops[i]));
            end
        end
        run_instr(r_type(5'd2, 5'd1, 5'd23, 5'd0, FUNCT_SLTU));  // r1 has bit 31 set.
        compare_word("result", result, 32'd1);
        run_instr(r_type(5'd1, 5'd2, 5'd24, 5'd0, FUNCT_SLTU));
    endtask

    task automatic test_shifts();
        shamt_t    amounts [3];
        reg_addr_t srcs [2];
        amounts = '{5'd0, 5'd1, 5'd31};
        srcs    = '{5'd26, 5'd5};
        for (int i = 0; i < 3; i++) begin
            run_instr(r_type(5'd0, 5'd1, 5'd25, amounts[i], FUNCT_SLL));
            run_instr(r_type(5'd0, 5'd1, 5'd25, amounts[i], FUNCT_SRL));
            run_instr(r_type(5'd0, 5'd1, 5'd25, amounts[i], FUNCT_SRA));
            if (amounts[i] == 5'd31) begin
                compare_word("result", result, 32'hffff_ffff);  // Sign fill.
            end
        end
        run_instr(r_type(5'd0, 5'd2, 5'd25, 5'd1, FUNCT_SRA));
        run_instr(i_type(OPCODE_ADDIU, 5'd0, 5'd26, 16'h0025));  // Amount 37.
        for (int i = 0; i < 2; i++) begin
            run_instr(r_type(srcs[i], 5'd1, 5'd27, 5'd0, FUNCT_SLLV));
            run_instr(r_type(srcs[i], 5'd1, 5'd27, 5'd0, FUNCT_SRLV));
            run_instr(r_type(srcs[i], 5'd1, 5'd27, 5'd0, FUNCT_SRAV));
        end
    endtask

    task automatic test_back_to_back();
        word_t exp_res;
        logic  exp_ill;
        chain_q = {};
        chain_q.push_back(i_type(OPCODE_ADDIU, 5'd1, 5'd28, 16'h1234));
        chain_q.push_back(r_type(5'd28, 5'd2, 5'd29, 5'd0, FUNCT_ADDU));
        chain_q.push_back(r_type(5'd29, 5'd28, 5'd30, 5'd0, FUNCT_XOR));
        chain_q.push_back(r_type(5'd30, 5'd29, 5'd31, 5'd0, FUNCT_SUBU));
        chain_q.push_back(r_type(5'd30, 5'd31, 5'd28, 5'd0, FUNCT_SRAV));
        chain_q.push_back(r_type(5'd28, 5'd31, 5'd29, 5'd0, FUNCT_SLTU));
        for (int i = 0; i < chain_q.size(); i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_outputs(exp_res, exp_ill);  // Result of the word before.
            end
            model_step(chain_q[i], exp_res, exp_ill);
            instr       = chain_q[i];
            instr_valid = 1'b1;
        end
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = '0;
        wait_result();
        check_outputs(exp_res, exp_ill);
    endtask

    task automatic test_illegal();
        run_instr(r_type(5'd1, 5'd2, 5'd5, 5'd0, 6'h3f));        // Unused funct.
        run_instr(r_type(5'd5, 5'd0, 5'd12, 5'd0, FUNCT_OR));
        run_instr(i_type(6'h23, 5'd1, 5'd6, 16'h3004));          // Load, rd field also r6.
        run_instr(r_type(5'd6, 5'd0, 5'd13, 5'd0, FUNCT_OR));
    endtask

    // ==================================================
    // Sequence
    // ==================================================
    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        foreach (shadow[k]) begin
            shadow[k] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_immediate();
        test_alu_logic();
        test_shifts();
        test_back_to_back();
        test_illegal();
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
